/* priv_trap.f */
source/priv_pkg.sv
source/irq_sync.sv
source/intr_deleg_regs.sv
source/trap_level_regs.sv
source/trap_ctrl.sv
source/csr_read_mux.sv
source/priv_trap_unit.sv
test/tb_clock_gen.sv
test/priv_trap_unit_sva.sv
test/tb_priv_trap_unit.sv

/* Bender.yml */
package:
  name: priv_trap

sources:
  - files:
      - source/priv_pkg.sv
      - source/irq_sync.sv
      - source/intr_deleg_regs.sv
      - source/trap_level_regs.sv
      - source/trap_ctrl.sv
      - source/csr_read_mux.sv
      - source/priv_trap_unit.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/priv_trap_unit_sva.sv
      - test/tb_priv_trap_unit.sv

/* test/tb_priv_trap_unit.sv */
// testbench top for the privileged trap unit.
// csr readback, exception and interrupt entry, mret/sret and delegation tests.
`timescale 1ns/100ps
`default_nettype none

module tb_priv_trap_unit import priv_pkg::*; ();

    logic            clk;
    logic            srstn;
    trap_req_t       trap_req;
    csr_cmd_t        csr_cmd;
    logic [11:0]     csr_raddr;
    irq_lines_t      irq_lines;
    trap_resp_t      trap_resp;
    logic [xlen-1:0] csr_rdata;
    priv_t           prv;
    logic            wakeup;

    int seed;
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .srstn (srstn)
    );

    priv_trap_unit priv_trap_unit_inst (
        .clk       (clk),
        .srstn     (srstn),
        .trap_req  (trap_req),
        .csr_cmd   (csr_cmd),
        .csr_raddr (csr_raddr),
        .irq_lines (irq_lines),
        .trap_resp (trap_resp),
        .csr_rdata (csr_rdata),
        .prv       (prv),
        .wakeup    (wakeup)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (srstn !== 1'b1 && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (srstn !== 1'b1) begin
            $display("reset was not released within 50 cycles");
            test_errors++;
        end
    endtask

    // a write is taken at the second edge and is readable after it.
    task automatic csr_write(input logic [11:0] addr, input logic [31:0] data);
        @(posedge clk);
        csr_cmd <= '{wr: 1'b1, waddr: addr, wdata: data};
        @(posedge clk);
        csr_cmd.wr <= 1'b0;
    endtask

    task automatic csr_read(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        csr_raddr <= addr;
        @(negedge clk);
        data = csr_rdata;
    endtask

    // the response is sampled mid-cycle, the state update lands at the next edge.
    task automatic issue_req(input trap_req_t req, output trap_resp_t resp);
        @(posedge clk);
        trap_req <= req;
        @(negedge clk);
        resp = trap_resp;
        @(posedge clk);
        trap_req <= '0;
    endtask

    task automatic wait_irq(input int max_cycles, output logic seen);
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(negedge clk);
            seen = trap_resp.irq_trigger;
        end
        if (!seen) begin
            $display("irq_trigger did not rise within %0d cycles", max_cycles);
            test_errors++;
        end
    endtask

    task automatic test_reset();
        logic [31:0] data;
        check_value("prv", 32'(prv), 32'h3);
        check_value("irq_trigger", 32'(trap_resp.irq_trigger), 32'h0);
        check_value("eret_en", 32'(trap_resp.eret_en), 32'h0);
        check_value("wakeup", 32'(wakeup), 32'h0);
        csr_read(csr_mstatus, data);
        check_value("mstatus", data, 32'h0);
        csr_read(csr_misa, data);
        // mxl 1, then the extension letters a, c, i, m, s and u.
        check_value("misa", data, (32'd1 << 30) | (32'd1 << 0) | (32'd1 << 2) |
                    (32'd1 << 8) | (32'd1 << 12) | (32'd1 << 18) | (32'd1 << 20));
    endtask

    task automatic test_csr_readback();
        logic [11:0] addrs [6];
        logic [31:0] cleared [6];
        logic [31:0] wdata;
        logic [31:0] data;
        addrs   = '{csr_mscratch, csr_sscratch, csr_mtvec, csr_stvec, csr_mepc, csr_sepc};
        cleared = '{32'h0, 32'h0, 32'h2, 32'h2, 32'h1, 32'h1};
        for (int i = 0; i < 6; i++) begin
            wdata = $random(seed);
            csr_write(addrs[i], wdata);
            csr_read(addrs[i], data);
            check_value($sformatf("csr_rdata[%03h]", addrs[i]), data, wdata & ~cleared[i]);
        end
        wdata = $random(seed);
        csr_write(csr_mstatus, wdata);
        csr_read(csr_sstatus, data);
        // sstatus shows only sie, spie and spp.
        check_value("sstatus", data, wdata & 32'h0000_0122);
    endtask

    task automatic test_m_exception();
        trap_req_t   req;
        trap_resp_t  resp;
        logic [31:0] tvec;
        logic [31:0] epc;
        logic [31:0] tval;
        logic [31:0] data;
        tvec = $random(seed);
        csr_write(csr_mtvec, tvec);
        tvec = tvec & ~32'h2;
        csr_write(csr_mstatus, 32'h0000_0008);
        epc  = $random(seed);
        tval = $random(seed);
        req       = '0;
        req.en    = 1'b1;
        req.epc   = epc;
        req.cause = 32'd2;
        req.tval  = tval;
        // a return in the same cycle loses to the trap.
        req.mret  = 1'b1;
        issue_req(req, resp);
        check_value("trap_vec", resp.trap_vec, tvec & ~32'h3);
        check_value("cause", resp.cause, 32'd2);
        check_value("tval", resp.tval, tval);
        check_value("irq_trigger", 32'(resp.irq_trigger), 32'h0);
        check_value("eret_en", 32'(resp.eret_en), 32'h0);
        csr_read(csr_mepc, data);
        check_value("mepc", data, epc);
        csr_read(csr_mcause, data);
        check_value("mcause", data, 32'd2);
        csr_read(csr_mtval, data);
        check_value("mtval", data, tval);
        // mpp is m, mpie holds the old mie, mie is clear.
        csr_read(csr_mstatus, data);
        check_value("mstatus", data, 32'h0000_1880);
        // mpp of 2 is reserved, so mpp stays m.
        csr_write(csr_mstatus, 32'h0000_1080);
        csr_read(csr_mstatus, data);
        check_value("mstatus", data, 32'h0000_1880);
        req      = '0;
        req.mret = 1'b1;
        issue_req(req, resp);
        check_value("eret_en", 32'(resp.eret_en), 32'h1);
        check_value("ret_epc", resp.ret_epc, epc);
        csr_read(csr_mstatus, data);
        check_value("prv", 32'(prv), 32'h3);
        check_value("mstatus", data, 32'h0000_0088);
    endtask

    task automatic test_s_exception();
        trap_req_t   req;
        trap_resp_t  resp;
        logic [31:0] tvec;
        logic [31:0] epc;
        logic [31:0] data;
        csr_write(csr_mstatus, 32'h0);
        req      = '0;
        req.mret = 1'b1;
        issue_req(req, resp);
        @(negedge clk);
        check_value("prv", 32'(prv), 32'h0);
        // ecall from u mode is cause 8.
        csr_write(csr_medeleg, 32'h0000_0100);
        tvec = $random(seed);
        csr_write(csr_stvec, tvec);
        tvec      = tvec & ~32'h2;
        epc       = $random(seed);
        req       = '0;
        req.en    = 1'b1;
        req.epc   = epc;
        req.cause = 32'd8;
        issue_req(req, resp);
        check_value("trap_vec", resp.trap_vec, tvec & ~32'h3);
        check_value("cause", resp.cause, 32'd8);
        csr_read(csr_scause, data);
        check_value("scause", data, 32'd8);
        check_value("prv", 32'(prv), 32'h1);
        csr_read(csr_sepc, data);
        check_value("sepc", data, epc);
        req      = '0;
        req.sret = 1'b1;
        issue_req(req, resp);
        check_value("eret_en", 32'(resp.eret_en), 32'h1);
        check_value("ret_epc", resp.ret_epc, epc);
        @(negedge clk);
        check_value("prv", 32'(prv), 32'h0);
    endtask

    task automatic test_m_interrupt();
        logic [31:0] base;
        logic        seen;
        base = $random(seed) & ~32'h3;
        csr_write(csr_mtvec, base | 32'h1);
        csr_write(csr_mie, 32'h0000_0080);
        csr_write(csr_mstatus, 32'h0000_0008);
        @(posedge clk);
        csr_raddr      <= csr_mstatus;
        irq_lines.mtip <= 1'b1;
        wait_irq(20, seen);
        if (seen) begin
            check_value("cause", trap_resp.cause, 32'h8000_0007);
            check_value("trap_vec", trap_resp.trap_vec, base + 32'd28);
            // mtip is pending and enabled.
            check_value("wakeup", 32'(wakeup), 32'h1);
            @(negedge clk);
            check_value("irq_trigger", 32'(trap_resp.irq_trigger), 32'h0);
            check_value("mstatus.mie", 32'(csr_rdata[3]), 32'h0);
            check_value("prv", 32'(prv), 32'h3);
        end
        @(posedge clk);
        irq_lines.mtip <= 1'b0;
        csr_write(csr_mie, 32'h0);
    endtask

    task automatic test_priority_deleg();
        trap_req_t   req;
        trap_resp_t  resp;
        logic [31:0] tvec;
        logic [31:0] data;
        logic        seen;
        csr_write(csr_mie, 32'h0000_0880);
        csr_write(csr_mstatus, 32'h0000_0008);
        @(posedge clk);
        irq_lines.meip <= 1'b1;
        irq_lines.mtip <= 1'b1;
        wait_irq(20, seen);
        if (seen) begin
            check_value("cause", trap_resp.cause, 32'h8000_000b);
        end
        @(posedge clk);
        irq_lines <= '0;
        // only the supervisor timer interrupt, delegated to s.
        csr_write(csr_mie, 32'h0000_0020);
        csr_write(csr_mideleg, 32'h0000_0020);
        tvec = $random(seed) & ~32'h3;
        csr_write(csr_stvec, tvec);
        csr_write(csr_mstatus, 32'h0);
        req      = '0;
        req.mret = 1'b1;
        issue_req(req, resp);
        // ssip is pending too but not delegated, so sip hides it.
        csr_write(csr_mip, 32'h0000_0022);
        wait_irq(20, seen);
        if (seen) begin
            check_value("cause", trap_resp.cause, 32'h8000_0005);
            check_value("trap_vec", trap_resp.trap_vec, tvec);
        end
        csr_read(csr_sip, data);
        check_value("sip", data, 32'h0000_0020);
        check_value("prv", 32'(prv), 32'h1);
        csr_write(csr_mip, 32'h0);
    endtask

    initial begin
        seed         = 85;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        trap_req     = '0;
        csr_cmd      = '0;
        csr_raddr    = '0;
        irq_lines    = '0;
        wait_reset();
        test_reset();
        end_test("reset values");
        test_csr_readback();
        end_test("csr readback");
        test_m_exception();
        end_test("machine exception and mret");
        test_s_exception();
        end_test("delegated exception and sret");
        test_m_interrupt();
        end_test("vectored machine interrupt");
        test_priority_deleg();
        end_test("interrupt priority and delegation");
        @(posedge clk);
        $display("%0d tests, %0d failed, %0d check errors, %0d assertion errors",
                 tests_run, tests_failed, total_errors,
                 priv_trap_unit_inst.priv_trap_unit_sva_inst.error_count);
        if (total_errors == 0 && priv_trap_unit_inst.priv_trap_unit_sva_inst.error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/priv_trap_unit_sva.sv */
// concurrent assertions on the trap response and the privilege level.
// bound into the top level of the trap unit.
`timescale 1ns/100ps
`default_nettype none

module priv_trap_unit_sva import priv_pkg::*; (
    input wire logic       clk,
    input wire logic       srstn,
    input wire trap_req_t  trap_req,
    input wire trap_resp_t trap_resp,
    input wire priv_t      prv
);

    int error_count = 0;

    // a trap request masks both the return and the interrupt.
    no_resp_during_trap: assert property (
        @(posedge clk) disable iff (!srstn)
        trap_req.en |-> !trap_resp.eret_en && !trap_resp.irq_trigger
    ) else begin
        error_count++;
        $error("eret_en or irq_trigger high during a trap request");
    end

    irq_cause_legal: assert property (
        @(posedge clk) disable iff (!srstn)
        trap_resp.irq_trigger |-> trap_resp.cause[31] && trap_resp.cause[30:4] == '0 &&
            trap_resp.cause[3:0] inside {4'd1, 4'd3, 4'd5, 4'd7, 4'd9, 4'd11}
    ) else begin
        error_count++;
        $error("interrupt cause 0x%08h is not a legal interrupt", trap_resp.cause);
    end

    prv_legal: assert property (
        @(posedge clk) disable iff (!srstn)
        prv != 2'd2
    ) else begin
        error_count++;
        $error("privilege level holds the reserved value 2");
    end

endmodule

bind priv_trap_unit priv_trap_unit_sva priv_trap_unit_sva_inst (
    .clk       (clk),
    .srstn     (srstn),
    .trap_req  (trap_req),
    .trap_resp (trap_resp),
    .prv       (prv)
);

`default_nettype wire

/* test/tb_clock_gen.sv */
// testbench clock and reset generator.
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic srstn
);

    // 10 ns period.
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        srstn = 1'b0;
        repeat (10) @(posedge clk);
        srstn <= 1'b1;
    end

endmodule

`default_nettype wire

/* source/priv_trap_unit.sv */
// top level of the privileged trap unit.
`timescale 1ns/100ps
`default_nettype none

module priv_trap_unit import priv_pkg::*; (
    input  wire logic        clk,
    input  wire logic        srstn,
    input  wire trap_req_t   trap_req,
    input  wire csr_cmd_t    csr_cmd,
    input  wire logic [11:0] csr_raddr,
    input  wire irq_lines_t  irq_lines,
    output trap_resp_t       trap_resp,
    output logic [xlen-1:0]  csr_rdata,
    output priv_t            prv,
    output logic             wakeup
);

    irq_lines_t      irq_synced;
    intr_view_t      view;
    trap_capture_t   m_capture;
    trap_capture_t   s_capture;
    level_csr_t      m_bank;
    level_csr_t      s_bank;
    logic [xlen-1:0] mstatus;

    irq_sync irq_sync_inst (
        .clk       (clk),
        .srstn     (srstn),
        .lines_in  (irq_lines),
        .lines_out (irq_synced)
    );

    intr_deleg_regs intr_deleg_regs_inst (
        .clk     (clk),
        .srstn   (srstn),
        .csr_cmd (csr_cmd),
        .irq     (irq_synced),
        .view    (view),
        .wakeup  (wakeup)
    );

    trap_ctrl trap_ctrl_inst (
        .clk       (clk),
        .srstn     (srstn),
        .trap_req  (trap_req),
        .csr_cmd   (csr_cmd),
        .view      (view),
        .m_regs    (m_bank),
        .s_regs    (s_bank),
        .m_capture (m_capture),
        .s_capture (s_capture),
        .resp      (trap_resp),
        .prv       (prv),
        .mstatus   (mstatus)
    );

    trap_level_regs #(.csr_base(csr_base_m)) m_regs (
        .clk     (clk),
        .srstn   (srstn),
        .csr_cmd (csr_cmd),
        .capture (m_capture),
        .regs    (m_bank)
    );

    trap_level_regs #(.csr_base(csr_base_s)) s_regs (
        .clk     (clk),
        .srstn   (srstn),
        .csr_cmd (csr_cmd),
        .capture (s_capture),
        .regs    (s_bank)
    );

    csr_read_mux csr_read_mux_inst (
        .raddr   (csr_raddr),
        .mstatus (mstatus),
        .view    (view),
        .m_regs  (m_bank),
        .s_regs  (s_bank),
        .rdata   (csr_rdata)
    );

endmodule

`default_nettype wire

/* source/csr_read_mux.sv */
// csr read decoding, with the restricted supervisor views.
`timescale 1ns/100ps
`default_nettype none

module csr_read_mux import priv_pkg::*; (
    input  wire logic [11:0]     raddr,
    input  wire logic [xlen-1:0] mstatus,
    input  wire intr_view_t      view,
    input  wire level_csr_t      m_regs,
    input  wire level_csr_t      s_regs,
    output logic [xlen-1:0]      rdata
);

    always_comb begin
        rdata = '0;
        case (raddr)
            csr_sstatus:  rdata = mstatus & sstatus_mask;
            csr_sie:      rdata = view.mie & view.mideleg;
            csr_stvec:    rdata = s_regs.tvec;
            csr_sscratch: rdata = s_regs.scratch;
            csr_sepc:     rdata = s_regs.epc;
            csr_scause:   rdata = s_regs.cause;
            csr_stval:    rdata = s_regs.tval;
            csr_sip:      rdata = view.mip & view.mideleg;
            csr_mstatus:  rdata = mstatus;
            csr_misa:     rdata = misa_value;
            csr_medeleg:  rdata = view.medeleg;
            csr_mideleg:  rdata = view.mideleg;
            csr_mie:      rdata = view.mie;
            csr_mtvec:    rdata = m_regs.tvec;
            csr_mscratch: rdata = m_regs.scratch;
            csr_mepc:     rdata = m_regs.epc;
            csr_mcause:   rdata = m_regs.cause;
            csr_mtval:    rdata = m_regs.tval;
            csr_mip:      rdata = view.mip;
            default:      rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/trap_ctrl.sv */
// privilege level, mstatus interrupt stack and trap control.
// selects the target mode, arbitrates interrupts and builds the trap vector.
`timescale 1ns/100ps
`default_nettype none

module trap_ctrl import priv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       srstn,
    input  wire trap_req_t  trap_req,
    input  wire csr_cmd_t   csr_cmd,
    input  wire intr_view_t view,
    input  wire level_csr_t m_regs,
    input  wire level_csr_t s_regs,
    output trap_capture_t   m_capture,
    output trap_capture_t   s_capture,
    output trap_resp_t      resp,
    output priv_t           prv,
    output logic [xlen-1:0] mstatus
);

    logic            st_sie;
    logic            st_mie;
    logic            st_spie;
    logic            st_mpie;
    logic            st_spp;
    priv_t           st_mpp;
    logic            exc_to_s;
    logic            int_m;
    logic            int_s;
    logic            take_int;
    logic            target_s;
    logic [3:0]      irq_code;
    logic [xlen-1:0] tvec_sel;
    logic [xlen-1:0] vec_offset;

    // fixed priority mei, msi, mti, sei, ssi, sti.
    function automatic logic [3:0] pick_code(input logic [xlen-1:0] pend);
        logic [3:0] code;
        if (pend[irq_mei])      code = 4'(irq_mei);
        else if (pend[irq_msi]) code = 4'(irq_msi);
        else if (pend[irq_mti]) code = 4'(irq_mti);
        else if (pend[irq_sei]) code = 4'(irq_sei);
        else if (pend[irq_ssi]) code = 4'(irq_ssi);
        else                    code = 4'(irq_sti);
        return code;
    endfunction

    assign exc_to_s = prv != prv_m && trap_req.cause[xlen-2:5] == '0 &&
                      view.medeleg[trap_req.cause[4:0]];
    assign int_m    = |view.pend_m && (prv != prv_m || st_mie);
    assign int_s    = |view.pend_s && !int_m &&
                      (prv == prv_u || (prv == prv_s && st_sie));
    assign take_int = !trap_req.en && (int_m || int_s);
    assign target_s = trap_req.en ? exc_to_s : int_s;
    assign irq_code = pick_code(int_m ? view.pend_m : view.pend_s);

    assign tvec_sel   = target_s ? s_regs.tvec : m_regs.tvec;
    // vectored mode only applies to interrupts.
    assign vec_offset = (take_int && tvec_sel[0]) ? xlen'({irq_code, 2'b00}) : '0;

    assign resp.irq_trigger = take_int;
    assign resp.eret_en     = !trap_req.en && (trap_req.sret || trap_req.mret);
    assign resp.trap_vec    = (tvec_sel & ~32'h3) + vec_offset;
    assign resp.ret_epc     = trap_req.sret ? s_regs.epc : m_regs.epc;
    assign resp.cause       = trap_req.en ? trap_req.cause :
                              take_int    ? {1'b1, {(xlen-5){1'b0}}, irq_code} : '0;
    assign resp.tval        = trap_req.en ? trap_req.tval : '0;

    assign m_capture.en    = (trap_req.en || take_int) && !target_s;
    assign m_capture.epc   = trap_req.epc;
    assign m_capture.cause = resp.cause;
    assign m_capture.tval  = resp.tval;
    assign s_capture.en    = (trap_req.en || take_int) && target_s;
    assign s_capture.epc   = trap_req.epc;
    assign s_capture.cause = resp.cause;
    assign s_capture.tval  = resp.tval;

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            prv     <= prv_m;
            st_sie  <= 1'b0;
            st_mie  <= 1'b0;
            st_spie <= 1'b0;
            st_mpie <= 1'b0;
            st_spp  <= 1'b0;
            st_mpp  <= prv_u;
        end else if (trap_req.en || take_int) begin
            if (target_s) begin
                prv     <= prv_s;
                st_spp  <= prv[0];
                st_spie <= st_sie;
                st_sie  <= 1'b0;
            end else begin
                prv     <= prv_m;
                st_mpp  <= prv;
                st_mpie <= st_mie;
                st_mie  <= 1'b0;
            end
        end else if (trap_req.sret) begin
            prv     <= st_spp ? prv_s : prv_u;
            st_sie  <= st_spie;
            st_spie <= 1'b1;
            st_spp  <= 1'b0;
        end else if (trap_req.mret) begin
            prv     <= st_mpp;
            st_mie  <= st_mpie;
            st_mpie <= 1'b1;
            st_mpp  <= prv_u;
        end else if (csr_cmd.wr && csr_cmd.waddr == csr_sstatus) begin
            st_sie  <= csr_cmd.wdata[mstatus_sie];
            st_spie <= csr_cmd.wdata[mstatus_spie];
            st_spp  <= csr_cmd.wdata[mstatus_spp];
        end else if (csr_cmd.wr && csr_cmd.waddr == csr_mstatus) begin
            st_sie  <= csr_cmd.wdata[mstatus_sie];
            st_mie  <= csr_cmd.wdata[mstatus_mie];
            st_spie <= csr_cmd.wdata[mstatus_spie];
            st_mpie <= csr_cmd.wdata[mstatus_mpie];
            st_spp  <= csr_cmd.wdata[mstatus_spp];
            // the reserved level 2 leaves mpp unchanged.
            if (csr_cmd.wdata[mstatus_mpp+:2] != 2'd2) begin
                st_mpp <= priv_t'(csr_cmd.wdata[mstatus_mpp+:2]);
            end
        end
    end

    always_comb begin
        mstatus                  = '0;
        mstatus[mstatus_sie]     = st_sie;
        mstatus[mstatus_mie]     = st_mie;
        mstatus[mstatus_spie]    = st_spie;
        mstatus[mstatus_mpie]    = st_mpie;
        mstatus[mstatus_spp]     = st_spp;
        mstatus[mstatus_mpp+:2]  = st_mpp;
    end

endmodule

`default_nettype wire

/* source/trap_level_regs.sv */
// tvec, scratch, epc, cause and tval of one privilege level.
`timescale 1ns/100ps
`default_nettype none

module trap_level_regs import priv_pkg::*; #(
    parameter logic [11:0] csr_base = csr_base_m
) (
    input  wire logic          clk,
    input  wire logic          srstn,
    input  wire csr_cmd_t      csr_cmd,
    input  wire trap_capture_t capture,
    output level_csr_t         regs
);

    logic wr_tvec;
    logic wr_scratch;
    logic wr_epc;
    logic wr_cause;
    logic wr_tval;

    assign wr_tvec    = csr_cmd.wr && csr_cmd.waddr == csr_base + off_tvec;
    assign wr_scratch = csr_cmd.wr && csr_cmd.waddr == csr_base + off_scratch;
    assign wr_epc     = csr_cmd.wr && csr_cmd.waddr == csr_base + off_epc;
    assign wr_cause   = csr_cmd.wr && csr_cmd.waddr == csr_base + off_cause;
    assign wr_tval    = csr_cmd.wr && csr_cmd.waddr == csr_base + off_tval;

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            regs <= '0;
        end else begin
            // bit 1 of tvec is reserved in both modes.
            if (wr_tvec) begin
                regs.tvec <= csr_cmd.wdata & ~32'h2;
            end
            if (wr_scratch) begin
                regs.scratch <= csr_cmd.wdata;
            end
            // a trap entry wins over a csr write in the same cycle.
            if (capture.en) begin
                regs.epc   <= capture.epc;
                regs.cause <= capture.cause & cause_keep_mask;
                regs.tval  <= capture.tval;
            end else begin
                if (wr_epc) begin
                    regs.epc <= csr_cmd.wdata & ~32'h1;
                end
                if (wr_cause) begin
                    regs.cause <= csr_cmd.wdata & cause_keep_mask;
                end
                if (wr_tval) begin
                    regs.tval <= csr_cmd.wdata;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/intr_deleg_regs.sv */
// delegation, interrupt enable and interrupt pending registers.
// also forms the pending-and-enabled vectors for each target mode.
`timescale 1ns/100ps
`default_nettype none

module intr_deleg_regs import priv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       srstn,
    input  wire csr_cmd_t   csr_cmd,
    input  wire irq_lines_t irq,
    output intr_view_t      view,
    output logic            wakeup
);

    logic [xlen-1:0] medeleg_q;
    logic [xlen-1:0] mideleg_q;
    logic [xlen-1:0] mie_q;
    logic            ssip_q;
    logic            stip_q;
    logic            seip_sw_q;
    logic [xlen-1:0] mip;
    logic [xlen-1:0] active;

    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            medeleg_q <= '0;
            mideleg_q <= '0;
            mie_q     <= '0;
        end else if (csr_cmd.wr) begin
            case (csr_cmd.waddr)
                csr_medeleg: medeleg_q <= csr_cmd.wdata & deleg_exc_mask;
                csr_mideleg: mideleg_q <= csr_cmd.wdata & deleg_int_mask;
                csr_mie:     mie_q     <= csr_cmd.wdata & irq_mask;
                csr_sie:     mie_q     <= (mie_q & ~deleg_int_mask) |
                                          (csr_cmd.wdata & deleg_int_mask);
                default: ;
            endcase
        end
    end

    // software-writable pending bits.
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            ssip_q    <= 1'b0;
            stip_q    <= 1'b0;
            seip_sw_q <= 1'b0;
        end else if (csr_cmd.wr && csr_cmd.waddr == csr_mip) begin
            ssip_q    <= csr_cmd.wdata[irq_ssi];
            stip_q    <= csr_cmd.wdata[irq_sti];
            seip_sw_q <= csr_cmd.wdata[irq_sei];
        end else if (csr_cmd.wr && csr_cmd.waddr == csr_sip) begin
            ssip_q    <= csr_cmd.wdata[irq_ssi];
            seip_sw_q <= csr_cmd.wdata[irq_sei];
        end
    end

    always_comb begin
        mip          = '0;
        mip[irq_ssi] = ssip_q;
        mip[irq_msi] = irq.msip;
        mip[irq_sti] = stip_q;
        mip[irq_mti] = irq.mtip;
        mip[irq_sei] = irq.seip | seip_sw_q;
        mip[irq_mei] = irq.meip;
    end

    assign active = mie_q & mip;
    assign wakeup = |active;

    assign view.medeleg = medeleg_q;
    assign view.mideleg = mideleg_q;
    assign view.mie     = mie_q;
    assign view.mip     = mip;
    assign view.pend_m  = active & ~mideleg_q;
    assign view.pend_s  = active & mideleg_q;

endmodule

`default_nettype wire

/* source/irq_sync.sv */
// synchroniser for the external interrupt lines.
`timescale 1ns/100ps
`default_nettype none

module irq_sync import priv_pkg::*; (
    input  wire logic       clk,
    input  wire logic       srstn,
    input  wire irq_lines_t lines_in,
    output irq_lines_t      lines_out
);

    logic [irq_sync_stages-1:0][3:0] sync_q;

    // stage 0 samples the raw lines, the last stage feeds mip.
    always_ff @(posedge clk or negedge srstn) begin
        if (!srstn) begin
            sync_q <= '0;
        end else begin
            sync_q <= {sync_q[irq_sync_stages-2:0], lines_in};
        end
    end

    assign lines_out = irq_lines_t'(sync_q[irq_sync_stages-1]);

endmodule

`default_nettype wire

/* source/priv_pkg.sv */
// shared constants and types of the privileged trap unit.
// CSR addresses, interrupt and mstatus bit positions, masks and bus structs.
`default_nettype none

package priv_pkg;

    localparam int xlen            = 32;
    localparam int irq_sync_stages = 2;

    // supervisor csrs.
    localparam logic [11:0] csr_sstatus  = 12'h100;
    localparam logic [11:0] csr_sie      = 12'h104;
    localparam logic [11:0] csr_stvec    = 12'h105;
    localparam logic [11:0] csr_sscratch = 12'h140;
    localparam logic [11:0] csr_sepc     = 12'h141;
    localparam logic [11:0] csr_scause   = 12'h142;
    localparam logic [11:0] csr_stval    = 12'h143;
    localparam logic [11:0] csr_sip      = 12'h144;

    // machine csrs.
    localparam logic [11:0] csr_mstatus  = 12'h300;
    localparam logic [11:0] csr_misa     = 12'h301;
    localparam logic [11:0] csr_medeleg  = 12'h302;
    localparam logic [11:0] csr_mideleg  = 12'h303;
    localparam logic [11:0] csr_mie      = 12'h304;
    localparam logic [11:0] csr_mtvec    = 12'h305;
    localparam logic [11:0] csr_mscratch = 12'h340;
    localparam logic [11:0] csr_mepc     = 12'h341;
    localparam logic [11:0] csr_mcause   = 12'h342;
    localparam logic [11:0] csr_mtval    = 12'h343;
    localparam logic [11:0] csr_mip      = 12'h344;

    // per-level bank layout.
    localparam logic [11:0] csr_base_m  = 12'h300;
    localparam logic [11:0] csr_base_s  = 12'h100;
    localparam logic [11:0] off_tvec    = 12'h005;
    localparam logic [11:0] off_scratch = 12'h040;
    localparam logic [11:0] off_epc     = 12'h041;
    localparam logic [11:0] off_cause   = 12'h042;
    localparam logic [11:0] off_tval    = 12'h043;

    localparam int irq_ssi = 1;
    localparam int irq_msi = 3;
    localparam int irq_sti = 5;
    localparam int irq_mti = 7;
    localparam int irq_sei = 9;
    localparam int irq_mei = 11;

    localparam int mstatus_sie  = 1;
    localparam int mstatus_mie  = 3;
    localparam int mstatus_spie = 5;
    localparam int mstatus_mpie = 7;
    localparam int mstatus_spp  = 8;
    localparam int mstatus_mpp  = 11;

    localparam logic [xlen-1:0] irq_mask        = 32'h0000_0aaa;
    localparam logic [xlen-1:0] deleg_int_mask  = 32'h0000_0222;
    localparam logic [xlen-1:0] deleg_exc_mask  = 32'h0000_b109;
    localparam logic [xlen-1:0] sstatus_mask    = 32'h0000_0122;
    localparam logic [xlen-1:0] cause_keep_mask = 32'h8000_000f;
    // mxl 1 with a, c, i, m, s and u.
    localparam logic [xlen-1:0] misa_value      = 32'h4014_1105;

    typedef enum logic [1:0] {
        prv_u = 2'd0,
        prv_s = 2'd1,
        prv_m = 2'd3
    } priv_t;

    typedef struct packed {
        logic            wr;
        logic [11:0]     waddr;
        logic [xlen-1:0] wdata;
    } csr_cmd_t;

    typedef struct packed {
        logic            en;
        logic [xlen-1:0] epc;
        logic [xlen-1:0] cause;
        logic [xlen-1:0] tval;
        logic            sret;
        logic            mret;
    } trap_req_t;

    typedef struct packed {
        logic            irq_trigger;
        logic            eret_en;
        logic [xlen-1:0] trap_vec;
        logic [xlen-1:0] ret_epc;
        logic [xlen-1:0] cause;
        logic [xlen-1:0] tval;
    } trap_resp_t;

    typedef struct packed {
        logic msip;
        logic mtip;
        logic meip;
        logic seip;
    } irq_lines_t;

    typedef struct packed {
        logic [xlen-1:0] tvec;
        logic [xlen-1:0] scratch;
        logic [xlen-1:0] epc;
        logic [xlen-1:0] cause;
        logic [xlen-1:0] tval;
    } level_csr_t;

    typedef struct packed {
        logic            en;
        logic [xlen-1:0] epc;
        logic [xlen-1:0] cause;
        logic [xlen-1:0] tval;
    } trap_capture_t;

    typedef struct packed {
        logic [xlen-1:0] medeleg;
        logic [xlen-1:0] mideleg;
        logic [xlen-1:0] mie;
        logic [xlen-1:0] mip;
        logic [xlen-1:0] pend_m;
        logic [xlen-1:0] pend_s;
    } intr_view_t;

endpackage

`default_nettype wire
